// File: Bender.yml
package:
  name: mipsCpu

sources:
  - include_dirs:
      - .
    files:
      - mipsPkg.sv
      - registerFile.sv
      - mipsAlu.sv
      - multiCycleControl.sv
      - mipsDatapath.sv
      - mipsCpu.sv
  - target: test
    include_dirs:
      - .
    files:
      - mipsCpu_properties.sv
      - mipsCpu_tb.sv

// File: mipsAlu.sv
`timescale 1ns/1ps
`include "mipsCpu_config.svh"

module mipsAlu (
    input  mipsPkg::aluOpT           aluOp,
    input  mipsPkg::opcodeT          opcode,
    input  mipsPkg::functT           funct,
    input  logic [4:0]               shamt,
    input  logic [`MIPS_DATA_W-1:0]  a,
    input  logic [`MIPS_DATA_W-1:0]  b,
    output logic [`MIPS_DATA_W-1:0]  result,
    output logic                     zero
);
    import mipsPkg::*;

    aluFnT fn;

    // operation select
    always_comb begin
        fn = ALU_ADD;
        case (aluOp)
            ALUOP_ADD: fn = ALU_ADD;
            ALUOP_SUB: fn = ALU_SUB;
            ALUOP_FUNCT: begin
                case (funct)
                    FN_SUB:  fn = ALU_SUB;
                    FN_AND:  fn = ALU_AND;
                    FN_OR:   fn = ALU_OR;
                    FN_SLT:  fn = ALU_SLT;
                    FN_SLL:  fn = ALU_SLL;
                    FN_SRL:  fn = ALU_SRL;
                    default: fn = ALU_ADD;
                endcase
            end
            ALUOP_IMM: begin
                case (opcode)
                    OP_ANDI: fn = ALU_AND;
                    OP_ORI:  fn = ALU_OR;
                    OP_XORI: fn = ALU_XOR;
                    OP_SLTI: fn = ALU_SLT;
                    OP_LUI:  fn = ALU_LUI;
                    default: fn = ALU_ADD;
                endcase
            end
            default: fn = ALU_ADD;
        endcase
    end

    always_comb begin
        case (fn)
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            // signed compare
            ALU_SLT: result = {{(`MIPS_DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLL: result = b << shamt;
            ALU_SRL: result = b >> shamt;
            ALU_LUI: result = b << 16;
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: mipsCpu.f
+incdir+.
mipsPkg.sv
registerFile.sv
mipsAlu.sv
multiCycleControl.sv
mipsDatapath.sv
mipsCpu.sv
mipsCpu_properties.sv
mipsCpu_tb.sv

// File: mipsCpu.sv
`timescale 1ns/1ps
`include "mipsCpu_config.svh"

module mipsCpu (
    input  logic                    clk,
    input  logic                    rst,
    output mipsPkg::memReqT         memReq,
    input  logic [`MIPS_DATA_W-1:0] memRData,
    output mipsPkg::stateT          cpuState
);
    import mipsPkg::*;

    ctrlT   ctrl;
    opcodeT opcode;
    functT  funct;

    // step sequencer
    multiCycleControl control_i (
        .clk    (clk),
        .rst    (rst),
        .opcode (opcode),
        .funct  (funct),
        .ctrl   (ctrl),
        .state  (cpuState)
    );

    mipsDatapath datapath_i (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .opcode   (opcode),
        .funct    (funct),
        .memReq   (memReq),
        .memRData (memRData)
    );

endmodule

// File: mipsCpu_config.svh
`ifndef MIPS_CPU_CONFIG_SVH
`define MIPS_CPU_CONFIG_SVH

// word width of the core and of the memory bus
`define MIPS_DATA_W 32

// general purpose registers, register 0 reads as zero
`define MIPS_REG_COUNT 32

// address of the first instruction fetch
`define MIPS_RESET_PC 32'h0000_0000

`endif

// File: mipsCpu_properties.sv
`timescale 1ns/1ps
`include "mipsCpu_config.svh"

module mipsCpu_properties (
    input logic                    clk,
    input logic                    rst,
    input mipsPkg::memReqT         memReq,
    input logic [`MIPS_DATA_W-1:0] memRData,
    input mipsPkg::stateT          cpuState
);
    import mipsPkg::*;

    int unsigned failCount = 0;
    logic        fetch;
    logic        fiveStep;
    logic        fourStep;

    assign fetch = (cpuState == ST_FETCH) && memReq.read;

    // step count class of the word on the bus during a fetch
    always_comb begin
        fiveStep = 1'b0;
        fourStep = 1'b0;
        case (memRData[31:26])
            OP_LW: fiveStep = 1'b1;
            OP_SW, OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: fourStep = 1'b1;
            OP_RTYPE: begin
                fourStep = memRData[5:0] inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT,
                                                 FN_SLL, FN_SRL};
            end
            default: fourStep = 1'b0;
        endcase
    end

    resetQuiet: assert property (@(posedge clk)
        rst |-> (!memReq.read && !memReq.write && cpuState == ST_RESET))
    else begin
        $error("bus active or state not RESET while reset is held");
        failCount++;
    end

    // one RESET cycle, then the first fetch from the reset PC
    firstFetch: assert property (@(posedge clk)
        $fell(rst) |-> (cpuState == ST_RESET) ##1 (fetch && memReq.addr == `MIPS_RESET_PC))
    else begin
        $error("first fetch after reset missing or at the wrong address");
        failCount++;
    end

    oneStrobe: assert property (@(posedge clk) !(memReq.read && memReq.write))
    else begin
        $error("read and write strobes high in the same cycle");
        failCount++;
    end

    writeStep: assert property (@(posedge clk) disable iff (rst)
        memReq.write |-> cpuState == ST_MEM_WRITE)
    else begin
        $error("memory write outside the MEM_WRITE step");
        failCount++;
    end

    loadSteps: assert property (@(posedge clk) disable iff (rst)
        (fetch && fiveStep) |=> (!fetch)[*4] ##1 fetch)
    else begin
        $error("load did not take five cycles from fetch to fetch");
        failCount++;
    end

    fourSteps: assert property (@(posedge clk) disable iff (rst)
        (fetch && fourStep) |=> (!fetch)[*3] ##1 fetch)
    else begin
        $error("store, R-type or I-type did not take four cycles");
        failCount++;
    end

    // branches, jumps and illegal words
    threeSteps: assert property (@(posedge clk) disable iff (rst)
        (fetch && !fiveStep && !fourStep) |=> (!fetch)[*2] ##1 fetch)
    else begin
        $error("branch, jump or illegal word did not take three cycles");
        failCount++;
    end

endmodule

bind mipsCpu mipsCpu_properties props_i (
    .clk      (clk),
    .rst      (rst),
    .memReq   (memReq),
    .memRData (memRData),
    .cpuState (cpuState)
);

// File: mipsCpu_tb.sv
`timescale 1ns/1ps
`include "mipsCpu_config.svh"

module mipsCpu_tb;
    import mipsPkg::*;

    localparam logic [31:0] DATA_BASE   = 32'h0000_0200;
    localparam logic [31:0] RESULT_BASE = 32'h0000_0300;
    localparam logic [31:0] MARKER_BASE = 32'h0000_03C0;
    // word 43 holds the final jump to itself
    localparam logic [31:0] LOOP_ADDR   = 32'h0000_00AC;
    // five times the roughly 200 cycles the program needs
    localparam int TIMEOUT_CYCLES = 1000;

    logic                    clk;
    logic                    rst;
    memReqT                  memReq;
    logic [`MIPS_DATA_W-1:0] memRData;
    stateT                   cpuState;
    logic [31:0]             mem [256];
    logic [31:0]             d [4];
    logic [31:0]             expQ [$];
    int                      storeCount = 0;
    int                      dataErrors = 0;
    int                      cycles = 0;
    logic                    loopReached = 1'b0;

    mipsCpu dut_i (
        .clk      (clk),
        .rst      (rst),
        .memReq   (memReq),
        .memRData (memRData),
        .cpuState (cpuState)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] encodeR(input logic [5:0] fn, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [4:0] rd,
                                            input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] target);
        return {op, target};
    endfunction

    // results land on consecutive words from RESULT_BASE
    task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] expAddr;
        logic [31:0] expData;
        expAddr = RESULT_BASE + 32'(4 * storeCount);
        if (addr >= MARKER_BASE && addr < MARKER_BASE + 32'd16) begin
            $display("store at %0t hit marker address %h, a branch or jump went wrong",
                     $time, addr);
            dataErrors++;
        end else if (expQ.size() == 0) begin
            $display("store at %0t to %h is one more than the program makes", $time, addr);
            dataErrors++;
        end else begin
            expData = expQ.pop_front();
            assert (addr == expAddr) else begin
                $display("Fail time=%0t memReq.addr expected=%h actual=%h",
                         $time, expAddr, addr);
                dataErrors++;
            end
            assert (data == expData) else begin
                $display("Fail time=%0t memReq.wdata expected=%h actual=%h",
                         $time, expData, data);
                dataErrors++;
            end
            storeCount++;
        end
    endtask

    // unified memory with a combinational read
    assign memRData = mem[memReq.addr[9:2]];

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (!rst && memReq.write) begin
            checkStore(memReq.addr, memReq.wdata);
            mem[memReq.addr[9:2]] <= memReq.wdata;
        end
        if (!rst && memReq.read && cpuState == ST_FETCH && memReq.addr == LOOP_ADDR) begin
            loopReached <= 1'b1;
        end
    end

    initial begin
        void'($urandom(59));
        rst <= 1'b1;
        // illegal opcode 0x3F with the word address in the low bits
        for (int i = 0; i < 256; i++) begin
            mem[i] <= 32'hFC00_0000 | (i << 2);
        end
        for (int i = 0; i < 4; i++) begin
            d[i] = $urandom;
            mem[(DATA_BASE >> 2) + i] <= d[i];
            mem[i] <= encodeI(OP_LW, 5'd0, 5'(i + 1), 16'(DATA_BASE + 4 * i));
        end
        mem[4]  <= encodeR(FN_ADD, 5'd1, 5'd2, 5'd5, 5'd0);
        mem[6]  <= encodeR(FN_SUB, 5'd1, 5'd3, 5'd5, 5'd0);
        mem[8]  <= encodeR(FN_AND, 5'd2, 5'd3, 5'd5, 5'd0);
        mem[10] <= encodeR(FN_OR, 5'd3, 5'd4, 5'd5, 5'd0);
        mem[12] <= encodeR(FN_SLT, 5'd1, 5'd4, 5'd5, 5'd0);
        mem[14] <= encodeR(FN_SLL, 5'd0, 5'd2, 5'd5, 5'd5);
        mem[16] <= encodeR(FN_SRL, 5'd0, 5'd4, 5'd5, 5'd11);
        mem[18] <= encodeI(OP_ADDI, 5'd1, 5'd5, 16'hFFFD);
        mem[20] <= encodeI(OP_ANDI, 5'd2, 5'd5, 16'h8F0F);
        mem[22] <= encodeI(OP_ORI, 5'd3, 5'd5, 16'hF00F);
        mem[24] <= encodeI(OP_XORI, 5'd4, 5'd5, 16'hA5A5);
        mem[26] <= encodeI(OP_SLTI, 5'd1, 5'd5, 16'h8001);
        mem[28] <= encodeI(OP_LUI, 5'd0, 5'd5, 16'hBEEF);
        // each result in $5 goes to the next result word
        for (int k = 0; k < 13; k++) begin
            mem[5 + 2 * k] <= encodeI(OP_SW, 5'd0, 5'd5, 16'(RESULT_BASE + 4 * k));
        end
        mem[30] <= encodeI(OP_SW, 5'd0, 5'd4, 16'h0334);
        mem[31] <= encodeI(OP_BEQ, 5'd1, 5'd1, 16'd1);
        mem[32] <= encodeI(OP_SW, 5'd0, 5'd0, 16'h03C0);
        // $5 holds the nonzero lui result here
        mem[33] <= encodeI(OP_BEQ, 5'd0, 5'd5, 16'd1);
        mem[34] <= encodeI(OP_SW, 5'd0, 5'd1, 16'h0338);
        mem[35] <= encodeI(OP_BNE, 5'd0, 5'd5, 16'd1);
        mem[36] <= encodeI(OP_SW, 5'd0, 5'd0, 16'h03C4);
        mem[37] <= encodeI(OP_BNE, 5'd1, 5'd1, 16'd1);
        mem[38] <= encodeI(OP_SW, 5'd0, 5'd2, 16'h033C);
        // jal would link into $31 and restart at 0
        mem[39] <= encodeJ(6'h03, 26'd0);
        mem[40] <= encodeI(OP_SW, 5'd0, 5'd31, 16'h0340);
        mem[41] <= encodeJ(OP_J, 26'd43);
        mem[42] <= encodeI(OP_SW, 5'd0, 5'd0, 16'h03C8);
        mem[43] <= encodeJ(OP_J, 26'd43);

        expQ.push_back(d[0] + d[1]);
        expQ.push_back(d[0] - d[2]);
        expQ.push_back(d[1] & d[2]);
        expQ.push_back(d[2] | d[3]);
        expQ.push_back(($signed(d[0]) < $signed(d[3])) ? 32'd1 : 32'd0);
        expQ.push_back(d[1] << 5);
        expQ.push_back(d[3] >> 11);
        expQ.push_back(d[0] + 32'hFFFF_FFFD);
        expQ.push_back(d[1] & 32'h0000_8F0F);
        expQ.push_back(d[2] | 32'h0000_F00F);
        expQ.push_back(d[3] ^ 32'h0000_A5A5);
        expQ.push_back(($signed(d[0]) < $signed(32'hFFFF_8001)) ? 32'd1 : 32'd0);
        expQ.push_back(32'hBEEF_0000);
        // round trip and the not-taken branch stores before the $31 check
        expQ.push_back(d[3]);
        expQ.push_back(d[0]);
        expQ.push_back(d[1]);
        expQ.push_back(32'h0000_0000);

        repeat (8) @(negedge clk);
        rst <= 1'b0;
        while (!(loopReached && expQ.size() == 0) && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
        end
        if (!(loopReached && expQ.size() == 0)) begin
            $display("timeout: final loop not reached with all stores after %0d cycles",
                     cycles);
            dataErrors++;
        end
        $display("errors: %0d store checks, %0d protocol assertions",
                 dataErrors, dut_i.props_i.failCount);
        if (dataErrors == 0 && dut_i.props_i.failCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: mipsDatapath.sv
`timescale 1ns/1ps
`include "mipsCpu_config.svh"

module mipsDatapath (
    input  logic                    clk,
    input  logic                    rst,
    input  mipsPkg::ctrlT           ctrl,
    output mipsPkg::opcodeT         opcode,
    output mipsPkg::functT          funct,
    output mipsPkg::memReqT         memReq,
    input  logic [`MIPS_DATA_W-1:0] memRData
);
    import mipsPkg::*;

    logic [`MIPS_DATA_W-1:0] pc;
    logic [`MIPS_DATA_W-1:0] ir;
    logic [`MIPS_DATA_W-1:0] mdr;
    logic [`MIPS_DATA_W-1:0] regA;
    logic [`MIPS_DATA_W-1:0] regB;
    logic [`MIPS_DATA_W-1:0] aluOut;
    logic [`MIPS_DATA_W-1:0] rdata1;
    logic [`MIPS_DATA_W-1:0] rdata2;
    logic [`MIPS_DATA_W-1:0] srcA;
    logic [`MIPS_DATA_W-1:0] srcB;
    logic [`MIPS_DATA_W-1:0] aluResult;
    logic [`MIPS_DATA_W-1:0] nextPc;
    logic [`MIPS_DATA_W-1:0] immSign;
    logic [`MIPS_DATA_W-1:0] immExt;
    logic [`MIPS_DATA_W-1:0] regWData;
    logic [4:0]              regWAddr;
    logic                    zero;
    logic                    zeroExtImm;
    logic                    pcEn;

    assign opcode = opcodeT'(ir[31:26]);
    assign funct  = functT'(ir[5:0]);

    // logic immediates are zero-extended
    assign zeroExtImm = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
    assign immSign    = {{16{ir[15]}}, ir[15:0]};
    assign immExt     = zeroExtImm ? {16'h0000, ir[15:0]} : immSign;

    assign regWAddr = ctrl.regDst ? ir[15:11] : ir[20:16];
    assign regWData = ctrl.memToReg ? mdr : aluOut;

    registerFile regFile_i (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (ir[25:21]),
        .raddr2 (ir[20:16]),
        .waddr  (regWAddr),
        .we     (ctrl.regWrite),
        .wdata  (regWData),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    assign srcA = ctrl.aluSrcA ? regA : pc;

    always_comb begin
        case (ctrl.aluSrcB)
            SRCB_FOUR:    srcB = 32'd4;
            SRCB_IMM:     srcB = immExt;
            // branch offsets are always signed
            SRCB_IMM_SH2: srcB = immSign << 2;
            default:      srcB = regB;
        endcase
    end

    mipsAlu alu_i (
        .aluOp  (ctrl.aluOp),
        .opcode (opcode),
        .funct  (funct),
        .shamt  (ir[10:6]),
        .a      (srcA),
        .b      (srcB),
        .result (aluResult),
        .zero   (zero)
    );

    always_comb begin
        case (ctrl.pcSource)
            PC_ALU_OUT:     nextPc = aluOut;
            PC_JUMP_TARGET: nextPc = {pc[31:28], ir[25:0], 2'b00};
            default:        nextPc = aluResult;
        endcase
    end

    assign pcEn = ctrl.pcWrite
                || ((ctrl.branchCond == BR_EQ) && zero)
                || ((ctrl.branchCond == BR_NE) && !zero);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= `MIPS_RESET_PC;
            ir <= '0;
        end else begin
            if (pcEn) begin
                pc <= nextPc;
            end
            if (ctrl.irWrite) begin
                ir <= memRData;
            end
        end
    end

    // step registers, loaded every cycle
    always_ff @(posedge clk) begin
        mdr    <= memRData;
        regA   <= rdata1;
        regB   <= rdata2;
        aluOut <= aluResult;
    end

    assign memReq.addr  = ctrl.iorD ? aluOut : pc;
    assign memReq.wdata = regB;
    assign memReq.read  = ctrl.memRead;
    assign memReq.write = ctrl.memWrite;

endmodule

// File: mipsPkg.sv
`include "mipsCpu_config.svh"

package mipsPkg;

    // supported primary opcodes
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0A,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_XORI  = 6'h0E,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcodeT;

    // R-type function codes
    typedef enum logic [5:0] {
        FN_SLL = 6'h00,
        FN_SRL = 6'h02,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } functT;

    // instruction steps
    typedef enum logic [3:0] {
        ST_FETCH     = 4'h0,
        ST_DECODE    = 4'h1,
        ST_MEM_ADDR  = 4'h2,
        ST_MEM_READ  = 4'h3,
        ST_MEM_WB    = 4'h4,
        ST_MEM_WRITE = 4'h5,
        ST_R_EXEC    = 4'h6,
        ST_R_WB      = 4'h7,
        ST_BEQ_DONE  = 4'h8,
        ST_JUMP_DONE = 4'h9,
        ST_BNE_DONE  = 4'hA,
        ST_I_EXEC    = 4'hB,
        ST_I_WB      = 4'hC,
        ST_RESET     = 4'hF
    } stateT;

    // what decides the ALU operation
    typedef enum logic [1:0] {ALUOP_ADD, ALUOP_SUB, ALUOP_FUNCT, ALUOP_IMM} aluOpT;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } aluFnT;

    typedef enum logic [1:0] {SRCB_REG_B, SRCB_FOUR, SRCB_IMM, SRCB_IMM_SH2} aluSrcBT;

    typedef enum logic [1:0] {PC_ALU_RESULT, PC_ALU_OUT, PC_JUMP_TARGET} pcSrcT;

    typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branchCondT;

    // 17-bit control word
    typedef struct packed {
        branchCondT branchCond;
        logic       pcWrite;
        logic       iorD;
        logic       memRead;
        logic       memWrite;
        logic       memToReg;
        logic       irWrite;
        pcSrcT      pcSource;
        aluOpT      aluOp;
        logic       aluSrcA;
        aluSrcBT    aluSrcB;
        logic       regWrite;
        logic       regDst;
    } ctrlT;

    // unified memory request
    typedef struct packed {
        logic [`MIPS_DATA_W-1:0] addr;
        logic [`MIPS_DATA_W-1:0] wdata;
        logic                    read;
        logic                    write;
    } memReqT;

endpackage

// File: multiCycleControl.sv
`timescale 1ns/1ps

module multiCycleControl (
    input  logic            clk,
    input  logic            rst,
    input  mipsPkg::opcodeT opcode,
    input  mipsPkg::functT  funct,
    output mipsPkg::ctrlT   ctrl,
    output mipsPkg::stateT  state
);
    import mipsPkg::*;

    stateT nextState;
    logic  isMem;
    logic  isImm;
    logic  isR;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_RESET;
        end else begin
            state <= nextState;
        end
    end

    // instruction class from the instruction register
    always_comb begin
        isMem = 1'b0;
        isImm = 1'b0;
        isR   = 1'b0;
        case (opcode)
            OP_LW, OP_SW: isMem = 1'b1;
            OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_LUI: isImm = 1'b1;
            default: isMem = 1'b0;
        endcase
        // R-type only counts with a supported funct
        if (opcode == OP_RTYPE) begin
            case (funct)
                FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLL, FN_SRL: isR = 1'b1;
                default: isR = 1'b0;
            endcase
        end
    end

    always_comb begin
        ctrl      = '0;
        nextState = ST_RESET;
        case (state)
            ST_RESET: begin
                nextState = ST_FETCH;
            end
            ST_FETCH: begin
                // IR = mem[PC], PC += 4
                ctrl.memRead  = 1'b1;
                ctrl.irWrite  = 1'b1;
                ctrl.aluSrcB  = SRCB_FOUR;
                ctrl.aluOp    = ALUOP_ADD;
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = PC_ALU_RESULT;
                nextState     = ST_DECODE;
            end
            ST_DECODE: begin
                // branch target into ALUOut while A and B load
                ctrl.aluSrcB = SRCB_IMM_SH2;
                ctrl.aluOp   = ALUOP_ADD;
                if (isMem) begin
                    nextState = ST_MEM_ADDR;
                end else if (isR) begin
                    nextState = ST_R_EXEC;
                end else if (opcode == OP_BEQ) begin
                    nextState = ST_BEQ_DONE;
                end else if (opcode == OP_BNE) begin
                    nextState = ST_BNE_DONE;
                end else if (opcode == OP_J) begin
                    nextState = ST_JUMP_DONE;
                end else if (isImm) begin
                    nextState = ST_I_EXEC;
                end else begin
                    // illegal, instruction is skipped
                    nextState = ST_RESET;
                end
            end
            ST_MEM_ADDR: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = SRCB_IMM;
                ctrl.aluOp   = ALUOP_ADD;
                if (opcode == OP_LW) begin
                    nextState = ST_MEM_READ;
                end else if (opcode == OP_SW) begin
                    nextState = ST_MEM_WRITE;
                end else begin
                    nextState = ST_RESET;
                end
            end
            ST_MEM_READ: begin
                ctrl.memRead = 1'b1;
                ctrl.iorD    = 1'b1;
                nextState    = ST_MEM_WB;
            end
            ST_MEM_WB: begin
                // rt = MDR
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                nextState     = ST_FETCH;
            end
            ST_MEM_WRITE: begin
                ctrl.memWrite = 1'b1;
                ctrl.iorD     = 1'b1;
                nextState     = ST_FETCH;
            end
            ST_R_EXEC: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = SRCB_REG_B;
                ctrl.aluOp   = ALUOP_FUNCT;
                nextState    = ST_R_WB;
            end
            ST_R_WB: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                nextState     = ST_FETCH;
            end
            ST_BEQ_DONE, ST_BNE_DONE: begin
                // compare A with B, target already sits in ALUOut
                ctrl.aluSrcA    = 1'b1;
                ctrl.aluSrcB    = SRCB_REG_B;
                ctrl.aluOp      = ALUOP_SUB;
                ctrl.pcSource   = PC_ALU_OUT;
                ctrl.branchCond = (state == ST_BEQ_DONE) ? BR_EQ : BR_NE;
                nextState       = ST_FETCH;
            end
            ST_JUMP_DONE: begin
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = PC_JUMP_TARGET;
                nextState     = ST_FETCH;
            end
            ST_I_EXEC: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = SRCB_IMM;
                ctrl.aluOp   = ALUOP_IMM;
                nextState    = ST_I_WB;
            end
            ST_I_WB: begin
                // rt = ALUOut
                ctrl.regWrite = 1'b1;
                nextState     = ST_FETCH;
            end
            default: nextState = ST_RESET;
        endcase
    end

endmodule

// File: registerFile.sv
`timescale 1ns/1ps
`include "mipsCpu_config.svh"

module registerFile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [4:0]              raddr1,
    input  logic [4:0]              raddr2,
    input  logic [4:0]              waddr,
    input  logic                    we,
    input  logic [`MIPS_DATA_W-1:0] wdata,
    output logic [`MIPS_DATA_W-1:0] rdata1,
    output logic [`MIPS_DATA_W-1:0] rdata2
);

    logic [`MIPS_DATA_W-1:0] regs [`MIPS_REG_COUNT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads, $zero is hardwired
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule
